// ==== common/pooling_defs.svh ====
`ifndef POOLING_DEFS_SVH
`define POOLING_DEFS_SVH

// Width of one systolic array result and of one pooled output.
`define POOL_DATA_WIDTH 16

// Number of array columns, one pooling lane each.
`define POOL_COLS 8

// Results reduced per window. Must be a power of two.
`define POOL_WIN 4

// log2 of the window length, used as the averaging shift.
`define POOL_WIN_LOG2 2

// Partial-result entries per lane, used ping-pong by consecutive windows.
`define POOL_RF_DEPTH 2

`endif

// ==== common/pooling_pkg.sv ====
`include "pooling_defs.svh"

package pooling_pkg;

    // One array result or one pooled output.
    typedef logic [`POOL_DATA_WIDTH-1:0] pool_data_t;

    // Partial result. The extra bits hold a full window sum
    // of maximal samples without overflow.
    typedef logic [`POOL_DATA_WIDTH+`POOL_WIN_LOG2-1:0] pool_acc_t;

    // Reduction applied over one window.
    typedef enum logic {
        POOL_MAX = 1'b0,
        POOL_AVG = 1'b1
    } pool_mode_t;

    // Control word for one column in one cycle.
    // Column 0 gets it from the sequencer, the others through the skew chain.
    typedef struct packed {
        // Cycle carries window data.
        logic       active;
        // Load the sample instead of combining with the stored partial.
        logic       first;
        // Final sample of the window, register the result.
        logic       last;
        // Register file entry owned by this window.
        logic       slot;
        pool_mode_t mode;
    } pool_ctrl_t;

    // All column results side by side, element i belongs to column i.
    typedef pool_data_t [`POOL_COLS-1:0] pool_data_vec_t;

endpackage

// ==== pooling/pooling_regfile.sv ====
`timescale 1ns/1ns
`include "pooling_defs.svh"

module pooling_regfile (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   wr_en,
    input  logic                   slot,
    input  pooling_pkg::pool_acc_t wr_data,
    output pooling_pkg::pool_acc_t rd_data
);

    import pooling_pkg::*;

    // One entry per window in flight. Two windows can overlap
    // in a lane only through the ping-pong slots.
    pool_acc_t entry [`POOL_RF_DEPTH];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < `POOL_RF_DEPTH; i++)
            begin
                entry[i] <= '0;
            end
        end
        else if (wr_en)
        begin
            entry[slot] <= wr_data;
        end
    end

    // Read and write share the slot address, so a window reads its
    // own partial value and replaces it in the same cycle.
    assign rd_data = entry[slot];

endmodule

// ==== pooling/pooling_alu.sv ====
`timescale 1ns/1ns
`include "pooling_defs.svh"

module pooling_alu (
    input  pooling_pkg::pool_mode_t mode,
    input  pooling_pkg::pool_data_t sample,
    input  pooling_pkg::pool_acc_t  partial,
    output pooling_pkg::pool_acc_t  combined,
    output pooling_pkg::pool_data_t result
);

    import pooling_pkg::*;

    pool_acc_t sample_ext;

    // Unsigned data, zero extension is enough.
    assign sample_ext = pool_acc_t'(sample);

    always_comb
    begin
        case (mode)
            POOL_MAX:
            begin
                combined = (sample_ext > partial) ? sample_ext : partial;
                // A maximum never leaves the data range.
                result   = pool_data_t'(combined);
            end
            default:
            begin
                combined = sample_ext + partial;
                // Truncating mean, window is a power of two.
                result   = pool_data_t'(combined >> `POOL_WIN_LOG2);
            end
        endcase
    end

endmodule

// ==== pooling/pooling_lane.sv ====
`timescale 1ns/1ns

module pooling_lane (
    input  logic                    clk,
    input  logic                    rst,
    input  pooling_pkg::pool_ctrl_t ctrl,
    input  pooling_pkg::pool_data_t sample,
    output pooling_pkg::pool_data_t pool_out,
    output logic                    pool_done
);

    import pooling_pkg::*;

    pool_acc_t  rd_data;
    pool_acc_t  partial;
    pool_acc_t  combined;
    pool_data_t result;

    // Input select. Zero is neutral for unsigned max and for sum,
    // so the first sample goes through the normal combine path.
    assign partial = ctrl.first ? '0 : rd_data;

    pooling_regfile u_regfile (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (ctrl.active),
        .slot    (ctrl.slot),
        .wr_data (combined),
        .rd_data (rd_data)
    );

    pooling_alu u_alu (
        .mode     (ctrl.mode),
        .sample   (sample),
        .partial  (partial),
        .combined (combined),
        .result   (result)
    );

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            pool_out  <= '0;
            pool_done <= 1'b0;
        end
        else
        begin
            pool_done <= ctrl.active && ctrl.last;
            if (ctrl.active && ctrl.last)
                pool_out <= result;   // held until the next window ends
        end
    end

    // Even back to back windows are at least POOL_WIN cycles apart.
    a_done_single : assert property (
        @(posedge clk) disable iff (rst)
        pool_done |=> !pool_done
    );

endmodule

// ==== pooling/pooling_control.sv ====
`timescale 1ns/1ns
`include "pooling_defs.svh"

module pooling_control (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    start,
    input  pooling_pkg::pool_mode_t mode,
    output logic                    busy,
    output pooling_pkg::pool_ctrl_t ctrl
);

    localparam int unsigned CNT_W = (`POOL_WIN_LOG2 > 0) ? `POOL_WIN_LOG2 : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`POOL_WIN - 1);

    // Index of the sample that the current control word belongs to.
    logic [CNT_W-1:0] cnt;

    // Slot handed to the next accepted window.
    logic             slot_q;

    logic             accept;

    // The last cycle of a window already counts as free, so a new
    // start can follow directly and the windows run back to back.
    assign busy   = ctrl.active && !ctrl.last;
    assign accept = start && !busy;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            cnt    <= '0;
            slot_q <= 1'b0;
            ctrl   <= '0;
        end
        else if (accept)
        begin
            // New window. Mode is sampled together with start.
            cnt         <= '0;
            slot_q      <= ~slot_q;
            ctrl.active <= 1'b1;
            ctrl.first  <= 1'b1;
            ctrl.last   <= (CNT_LAST == '0);
            ctrl.slot   <= slot_q;
            ctrl.mode   <= mode;
        end
        else if (busy)
        begin
            cnt        <= cnt + 1'b1;
            ctrl.first <= 1'b0;
            ctrl.last  <= ((cnt + 1'b1) == CNT_LAST);
        end
        else
        begin
            // Idle. Slot and mode just keep their last value.
            ctrl.active <= 1'b0;
            ctrl.first  <= 1'b0;
            ctrl.last   <= 1'b0;
        end
    end

    // Window markers only ever appear on active cycles.
    a_markers_active : assert property (
        @(posedge clk) disable iff (rst)
        (ctrl.first || ctrl.last) |-> ctrl.active
    );

    // Every window spans exactly the configured number of samples.
    a_window_length : assert property (
        @(posedge clk) disable iff (rst)
        ctrl.first |-> ##(`POOL_WIN - 1) (ctrl.active && ctrl.last)
    );

endmodule

// ==== pooling/pooling_ctrl_skew.sv ====
`timescale 1ns/1ns
`include "pooling_defs.svh"

module pooling_ctrl_skew (
    input  logic                    clk,
    input  logic                    rst,
    input  pooling_pkg::pool_ctrl_t ctrl_in,
    output pooling_pkg::pool_ctrl_t ctrl_out [`POOL_COLS]
);

    import pooling_pkg::*;

    // Column 0 sees the sequencer output directly.
    assign ctrl_out[0] = ctrl_in;

    // One register per further column, matching the diagonal
    // skew of the systolic array outputs.
    generate
        for (genvar i = 1; i < `POOL_COLS; i++)
        begin : g_stage
            pool_ctrl_t stage_q;

            always_ff @(posedge clk)
            begin
                if (rst)
                    stage_q <= '0;
                else
                    stage_q <= ctrl_out[i-1];
            end

            assign ctrl_out[i] = stage_q;

            // The end of a window walks one column per cycle.
            a_last_walks : assert property (
                @(posedge clk) disable iff (rst)
                ctrl_out[i-1].last |=> ctrl_out[i].last
            );
        end
    endgenerate

endmodule

// ==== hdl/pooling_top.sv ====
`timescale 1ns/1ns
`include "pooling_defs.svh"

module pooling_top (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        start,
    input  pooling_pkg::pool_mode_t     mode,
    input  pooling_pkg::pool_data_vec_t sys_out,
    output logic                        busy,
    output pooling_pkg::pool_data_vec_t pool_out,
    output logic [`POOL_COLS-1:0]       pool_done
);

    import pooling_pkg::*;

    // Control word from the sequencer, before any skew.
    pool_ctrl_t ctrl_col0;

    // Control word seen by each column.
    pool_ctrl_t ctrl_cols [`POOL_COLS];

    pooling_control u_control (
        .clk   (clk),
        .rst   (rst),
        .start (start),
        .mode  (mode),
        .busy  (busy),
        .ctrl  (ctrl_col0)
    );

    pooling_ctrl_skew u_skew (
        .clk      (clk),
        .rst      (rst),
        .ctrl_in  (ctrl_col0),
        .ctrl_out (ctrl_cols)
    );

    // Column i gets its control i cycles late, in step with the
    // array results arriving on sys_out[i].
    generate
        for (genvar i = 0; i < `POOL_COLS; i++)
        begin : g_lane
            pooling_lane u_lane (
                .clk       (clk),
                .rst       (rst),
                .ctrl      (ctrl_cols[i]),
                .sample    (sys_out[i]),
                .pool_out  (pool_out[i]),
                .pool_done (pool_done[i])
            );
        end
    endgenerate

endmodule

// ==== test/pooling_tb.sv ====
`timescale 1ns/1ns
`include "pooling_defs.svh"

module pooling_tb;

    import pooling_pkg::*;

    localparam int ROWS         = 6;
    localparam int SCHED_LEN    = 128;
    localparam int RST_CYCLES   = 16;
    localparam int DONE_TIMEOUT = 64;
    localparam logic [31:0] LFSR_SEED = 32'hff71;

    // How the samples of a window are filled.
    localparam int FILL_RAND  = 0;
    localparam int FILL_EQUAL = 1;
    localparam int FILL_ZERO  = 2;
    localparam int FILL_FULL  = 3;

    logic           clk;
    logic           rst;
    logic           start;
    pool_mode_t     mode;
    pool_data_vec_t sys_out;
    logic           busy;
    pool_data_vec_t pool_out;
    logic [`POOL_COLS-1:0] pool_done;

    // Window table, one entry per row.
    string      row_name       [ROWS];
    pool_mode_t row_mode       [ROWS];
    int         row_gap        [ROWS];
    bit         row_busy_start [ROWS];
    int         row_fill       [ROWS];

    // Per edge stimulus and expectations, indexed by the edge that samples them.
    logic           start_sched [SCHED_LEN];
    pool_mode_t     mode_sched  [SCHED_LEN];
    pool_data_vec_t data_sched  [SCHED_LEN];
    logic           busy_exp    [SCHED_LEN];
    string          name_at     [SCHED_LEN];

    int         accept_edge [ROWS];
    pool_data_t exp_out     [ROWS][`POOL_COLS];

    pool_data_t held       [`POOL_COLS];
    int         next_row   [`POOL_COLS];
    int         done_count [`POOL_COLS];

    logic [31:0] lfsr_state;
    int          edge_cnt = 0;
    bit          checking = 1'b0;
    int          checks   = 0;
    int          errors   = 0;

    pooling_top dut_i (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .mode      (mode),
        .sys_out   (sys_out),
        .busy      (busy),
        .pool_out  (pool_out),
        .pool_done (pool_done)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk)
        edge_cnt <= edge_cnt + 1;

    // Taps 32, 22, 2, 1 give a maximal length sequence.
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        logic fb;
        fb = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], fb};
    endfunction

    task automatic draw_sample(output pool_data_t value);
        value = '0;
        for (int b = 0; b < `POOL_DATA_WIDTH; b++)
        begin
            lfsr_state = lfsr_step(lfsr_state);
            value = {value[`POOL_DATA_WIDTH-2:0], lfsr_state[0]};
        end
    endtask

    task automatic check_data(input string test, input string what,
                              input pool_data_t exp, input pool_data_t act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("[FAIL] %s %s: expected %h, got %h", test, what, exp, act);
        end
    endtask

    task automatic check_logic(input string test, input string what,
                               input logic exp, input logic act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("[FAIL] %s %s: expected %b, got %b", test, what, exp, act);
        end
    endtask

    task automatic check_int(input string test, input string what, input int exp, input int act);
        checks++;
        if (act != exp)
        begin
            errors++;
            $display("[FAIL] %s %s: expected %0d, got %0d", test, what, exp, act);
        end
    endtask

    task automatic set_row(input int r, input string name, input pool_mode_t m,
                           input int gap, input bit busy_start, input int fill);
        row_name[r]       = name;
        row_mode[r]       = m;
        row_gap[r]        = gap;
        row_busy_start[r] = busy_start;
        row_fill[r]       = fill;
    endtask

    // Gap is the number of idle cycles before start, zero runs back to back.
    task automatic load_table();
        set_row(0, "max_rand",  POOL_MAX, 2, 1'b0, FILL_RAND);
        set_row(1, "avg_rand",  POOL_AVG, 0, 1'b0, FILL_RAND);
        set_row(2, "max_equal", POOL_MAX, 0, 1'b0, FILL_EQUAL);
        set_row(3, "avg_full",  POOL_AVG, 3, 1'b0, FILL_FULL);
        set_row(4, "max_zero",  POOL_MAX, 0, 1'b0, FILL_ZERO);
        set_row(5, "avg_busy",  POOL_AVG, 1, 1'b1, FILL_RAND);
    endtask

    task automatic build_schedule();
        int         s;
        int         sum;
        pool_data_t v;
        pool_data_t maxv;
        lfsr_state = LFSR_SEED;
        for (int n = 0; n < SCHED_LEN; n++)
        begin
            start_sched[n] = 1'b0;
            mode_sched[n]  = POOL_MAX;
            // Outside a window the array output is junk that must never be used.
            data_sched[n]  = '1;
            busy_exp[n]    = 1'b0;
            name_at[n]     = "reset";
        end
        s = RST_CYCLES + 1;
        for (int r = 0; r < ROWS; r++)
        begin
            s = s + row_gap[r];
            accept_edge[r] = s;
            start_sched[s] = 1'b1;
            mode_sched[s]  = row_mode[r];
            for (int n = s - 1; n < SCHED_LEN; n++)
                name_at[n] = row_name[r];
            // Busy stays high until the edge before the last sample of column 0,
            // so a start sampled WIN edges later is accepted.
            for (int n = s; n <= s + `POOL_WIN - 2; n++)
                busy_exp[n] = 1'b1;
            if (row_busy_start[r])
            begin
                start_sched[s + 2] = 1'b1;
                mode_sched[s + 2]  = (row_mode[r] == POOL_MAX) ? POOL_AVG : POOL_MAX;
            end
            for (int i = 0; i < `POOL_COLS; i++)
            begin
                sum  = 0;
                maxv = '0;
                v    = '0;
                if (row_fill[r] == FILL_EQUAL)
                    draw_sample(v);
                for (int k = 0; k < `POOL_WIN; k++)
                begin
                    case (row_fill[r])
                        FILL_RAND: draw_sample(v);
                        FILL_ZERO: v = '0;
                        FILL_FULL: v = '1;
                        default:   v = v;
                    endcase
                    // Sample k of column i is taken at edge s+1+i+k.
                    data_sched[s + 1 + i + k][i] = v;
                    sum = sum + int'(v);
                    if (v > maxv)
                        maxv = v;
                end
                if (row_mode[r] == POOL_MAX)
                    exp_out[r][i] = maxv;
                else
                    exp_out[r][i] = pool_data_t'(sum >> `POOL_WIN_LOG2);
            end
            s = s + `POOL_WIN;
        end
    endtask

    function automatic bit all_windows_seen();
        for (int i = 0; i < `POOL_COLS; i++)
        begin
            if (next_row[i] < ROWS)
                return 1'b0;
        end
        return 1'b1;
    endfunction

    // Outputs are compared in the middle of the cycle.
    always @(negedge clk)
    begin : monitor
        int n;
        int r;
        if (checking)
        begin
            n = (edge_cnt < SCHED_LEN) ? edge_cnt : SCHED_LEN - 1;
            check_logic(name_at[n], "busy", busy_exp[n], busy);
            for (int i = 0; i < `POOL_COLS; i++)
            begin
                if (pool_done[i])
                begin
                    done_count[i]++;
                    if (next_row[i] < ROWS)
                    begin
                        r = next_row[i];
                        // Start is driven one edge before the edge that accepts it.
                        check_int(row_name[r], $sformatf("done offset col %0d", i),
                                  `POOL_WIN + 1 + i, edge_cnt - (accept_edge[r] - 1));
                        check_data(row_name[r], $sformatf("pool_out col %0d", i),
                                   exp_out[r][i], pool_out[i]);
                        held[i] = exp_out[r][i];
                        next_row[i]++;
                    end
                end
                else
                begin
                    check_data(name_at[n], $sformatf("held pool_out col %0d", i),
                               held[i], pool_out[i]);
                end
            end
        end
    end

    initial
    begin
        int waited;
        rst     = 1'b1;
        start   = 1'b0;
        mode    = POOL_MAX;
        sys_out = '0;
        for (int i = 0; i < `POOL_COLS; i++)
        begin
            held[i]       = '0;
            next_row[i]   = 0;
            done_count[i] = 0;
        end
        load_table();
        build_schedule();

        repeat (RST_CYCLES) @(posedge clk);
        rst      <= 1'b0;
        checking = 1'b1;

        for (int e = RST_CYCLES + 1; e < SCHED_LEN; e++)
        begin
            start   <= start_sched[e];
            mode    <= mode_sched[e];
            sys_out <= data_sched[e];
            @(posedge clk);
        end

        waited = 0;
        while (!all_windows_seen() && waited < DONE_TIMEOUT)
        begin
            @(negedge clk);
            waited++;
        end
        if (!all_windows_seen())
        begin
            errors++;
            $display("Timed out waiting for the pooled results of the last window.");
        end

        // The ignored start must not add a window.
        for (int i = 0; i < `POOL_COLS; i++)
            check_int("summary", $sformatf("done pulses col %0d", i), ROWS, done_count[i]);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+common
common/pooling_pkg.sv
pooling/pooling_regfile.sv
pooling/pooling_alu.sv
pooling/pooling_lane.sv
pooling/pooling_control.sv
pooling/pooling_ctrl_skew.sv
hdl/pooling_top.sv
test/pooling_tb.sv

// ==== Bender.yml ====
package:
  name: pooling

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/pooling_pkg.sv
      - pooling/pooling_regfile.sv
      - pooling/pooling_alu.sv
      - pooling/pooling_lane.sv
      - pooling/pooling_control.sv
      - pooling/pooling_ctrl_skew.sv
      - hdl/pooling_top.sv

  - target: test
    include_dirs:
      - common
    files:
      - test/pooling_tb.sv
